/* src/idct_math_pkg.sv */
package idct_math_pkg;

	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] prod_t;
	typedef logic signed [31:0] cos_t;
	typedef logic [7:0] pixel_t;

	localparam int BLOCK_DIM = 8;
	localparam int PAIRS = 4;

	// row sums are scaled back by 2^8, pixels sit at bit 16 of the column sum
	localparam int ROW_SHIFT = 8;
	localparam int COL_SHIFT = 16;

	// basis matrix scaled by 4096, first index is the input index k
	localparam cos_t COS_TABLE [BLOCK_DIM][BLOCK_DIM] = '{
		'{ 1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448},
		'{ 2008,  1702,  1137,   399,  -399, -1137, -1702, -2008},
		'{ 1892,   783,  -783, -1892, -1892,  -783,   783,  1892},
		'{ 1702,  -399, -2008, -1137,  1137,  2008,   399, -1702},
		'{ 1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448},
		'{ 1137, -2008,   399,  1702, -1702,  -399,  2008, -1137},
		'{  783, -1892,  1892,  -783,  -783,  1892, -1892,   783},
		'{  399, -1137,  1702, -2008,  2008, -1702,  1137,  -399}
	};

	typedef enum logic {
		ROW_PASS,
		COL_PASS
	} pass_e;

	// one lane step, four steps make one output element
	typedef struct packed {
		pass_e pass;
		logic [1:0] step;
		logic [2:0] out_index;
		logic first;
		logic last;
	} mac_ctrl_t;

endpackage

/* src/idct_mem_pkg.sv */
package idct_mem_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic [6:0] buf_addr_t;
	typedef logic [31:0] buf_data_t;

	// coefficients come from the upper SRAM region, pixels go to the bottom
	localparam sram_addr_t IN_BASE = 18'd76800;
	localparam sram_addr_t OUT_BASE = 18'd0;
	localparam int SRAM_READ_LATENCY = 2;

	// S' pairs in words 0..31, T in words 64..127
	localparam buf_addr_t T_BASE = 7'd64;

	typedef struct packed {
		buf_addr_t addr;
		buf_data_t data;
		logic we;
	} ram_req_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		ROW,
		COL,
		FLUSH,
		STORE,
		DONE
	} ctrl_state_e;

endpackage

/* src/dual_port_ram.sv */
`timescale 1ns/1ns

module dual_port_ram
	import idct_mem_pkg::*;
(
	input logic clock,
	input ram_req_t req_a,
	input ram_req_t req_b,
	output buf_data_t q_a,
	output buf_data_t q_b
);

	buf_data_t mem [2 ** $bits(buf_addr_t)];

	// read returns the old word on a same-cycle write
	always_ff @(posedge clock) begin
		if (req_a.we) begin
			mem[req_a.addr] <= req_a.data;
		end
		if (req_b.we) begin
			mem[req_b.addr] <= req_b.data;
		end
		q_a <= mem[req_a.addr];
		q_b <= mem[req_b.addr];
	end

endmodule

/* src/mac_lane.sv */
`timescale 1ns/1ns

module mac_lane
	import idct_math_pkg::*;
#(
	parameter int LANE_PARITY = 0
) (
	input logic clock,
	input logic resetn,
	input mac_ctrl_t ctrl,
	input logic valid,
	input prod_t sample,
	output prod_t product,
	output logic product_valid
);

	logic [2:0] k;
	cos_t coef_q;
	prod_t sample_q;
	logic operand_valid;

	// even lane covers k = 0,2,4,6, odd lane k = 1,3,5,7
	assign k = {ctrl.step, 1'(LANE_PARITY)};

	always_ff @(posedge clock) begin
		if (valid) begin
			coef_q <= COS_TABLE[k][ctrl.out_index];
			sample_q <= sample;
		end
		if (operand_valid) begin
			product <= coef_q * sample_q;
		end
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			operand_valid <= 1'b0;
			product_valid <= 1'b0;
		end else begin
			operand_valid <= valid;
			product_valid <= operand_valid;
		end
	end

endmodule

/* src/idct_datapath.sv */
`timescale 1ns/1ns

module idct_datapath
	import idct_math_pkg::*;
	import idct_mem_pkg::*;
(
	input logic clock,
	input logic resetn,
	input mac_ctrl_t ctrl,
	input logic valid,
	input buf_data_t q_a,
	input buf_data_t q_b,
	output buf_data_t result_value,
	output logic result_valid
);

	prod_t sample_even;
	prod_t sample_odd;
	prod_t product_even;
	prod_t product_odd;
	logic valid_even;
	logic valid_odd;
	mac_ctrl_t ctrl_d1;
	mac_ctrl_t ctrl_d2;
	prod_t acc;
	prod_t acc_next;
	pixel_t pixel;
	logic sum_step;

	always_comb begin
		if (ctrl.pass == ROW_PASS) begin
			// one word holds S'[r][2j] above S'[r][2j+1]
			sample_even = prod_t'(coef_t'(q_a[31:16]));
			sample_odd = prod_t'(coef_t'(q_a[15:0]));
		end else begin
			sample_even = prod_t'(q_a);
			sample_odd = prod_t'(q_b);
		end
	end

	mac_lane #(.LANE_PARITY(0)) u_lane_even (
		.clock(clock),
		.resetn(resetn),
		.ctrl(ctrl),
		.valid(valid),
		.sample(sample_even),
		.product(product_even),
		.product_valid(valid_even)
	);

	mac_lane #(.LANE_PARITY(1)) u_lane_odd (
		.clock(clock),
		.resetn(resetn),
		.ctrl(ctrl),
		.valid(valid),
		.sample(sample_odd),
		.product(product_odd),
		.product_valid(valid_odd)
	);

	assign sum_step = valid_even && valid_odd;
	assign acc_next = (ctrl_d2.first ? prod_t'(0) : acc) + product_even + product_odd;

	// saturate to 0..255 around the pixel byte
	always_comb begin
		if (acc_next[31]) begin
			pixel = '0;
		end else if (|acc_next[30:COL_SHIFT+8]) begin
			pixel = '1;
		end else begin
			pixel = acc_next[COL_SHIFT +: 8];
		end
	end

	// step info follows the two lane stages
	always_ff @(posedge clock) begin
		ctrl_d1 <= ctrl;
		ctrl_d2 <= ctrl_d1;
		if (sum_step) begin
			acc <= acc_next;
			if (ctrl_d2.last) begin
				if (ctrl_d2.pass == ROW_PASS) begin
					result_value <= buf_data_t'(acc_next >>> ROW_SHIFT);
				end else begin
					result_value <= buf_data_t'(pixel);
				end
			end
		end
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= sum_step && ctrl_d2.last;
		end
	end

endmodule

/* src/idct_control.sv */
`timescale 1ns/1ns

module idct_control
	import idct_math_pkg::*;
	import idct_mem_pkg::*;
(
	input logic clock,
	input logic resetn,
	input logic start,
	output logic done,
	output sram_addr_t sram_address,
	input sram_data_t sram_read_data,
	output sram_data_t sram_write_data,
	output logic sram_we_n,
	output ram_req_t req0_a,
	output ram_req_t req0_b,
	output ram_req_t req1_a,
	output ram_req_t req1_b,
	input buf_data_t q1_a,
	input buf_data_t q1_b,
	output mac_ctrl_t mac_ctrl,
	output logic mac_valid,
	input buf_data_t result_value,
	input logic result_valid
);

	ctrl_state_e state;
	logic [8:0] cnt;
	logic [5:0] res_cnt;
	sram_data_t s_hold;

	logic [8:0] fetch_idx;
	logic fetch_wr;
	logic streaming;
	logic [1:0] step;
	logic [2:0] idx_mid;
	logic [2:0] idx_hi;
	logic last_result;

	// cnt = {r, n, j} in ROW and {r, c, j} in COL
	assign step = cnt[1:0];
	assign idx_mid = cnt[4:2];
	assign idx_hi = cnt[7:5];
	assign streaming = !cnt[8];

	// coefficient arriving on the SRAM bus this cycle
	assign fetch_idx = cnt - 9'(SRAM_READ_LATENCY);
	assign fetch_wr = (cnt >= 9'(SRAM_READ_LATENCY)) && fetch_idx[0];
	assign last_result = result_valid && (res_cnt == 6'd63);

	always_comb begin
		req0_a = '0;
		req0_b = '0;
		req1_a = '0;
		req1_b = '0;
		case (state)
			FETCH: begin
				req0_b.addr = buf_addr_t'(fetch_idx[5:1]);
				req0_b.data = {s_hold, sram_read_data};
				req0_b.we = fetch_wr;
			end
			ROW: begin
				req0_a.addr = {2'b00, idx_hi, step};
				req0_b.addr = T_BASE + buf_addr_t'(res_cnt);
				req0_b.data = result_value;
				req0_b.we = result_valid;
			end
			COL, FLUSH: begin
				// T rows 2j and 2j+1 of column c
				req0_a.addr = T_BASE + buf_addr_t'({step, 1'b0, idx_mid});
				req0_b.addr = T_BASE + buf_addr_t'({step, 1'b1, idx_mid});
				req1_a.addr = buf_addr_t'(res_cnt);
				req1_a.data = result_value;
				req1_a.we = result_valid;
			end
			STORE: begin
				req1_a.addr = buf_addr_t'({cnt[4:0], 1'b0});
				req1_b.addr = buf_addr_t'({cnt[4:0], 1'b1});
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			state <= IDLE;
			cnt <= '0;
			res_cnt <= '0;
			mac_valid <= 1'b0;
			done <= 1'b0;
			sram_we_n <= 1'b1;
			sram_address <= IN_BASE;
		end else begin
			done <= 1'b0;
			mac_valid <= 1'b0;
			if (result_valid) begin
				res_cnt <= res_cnt + 6'd1;
			end
			case (state)
				IDLE: begin
					if (start) begin
						cnt <= '0;
						res_cnt <= '0;
						sram_address <= IN_BASE;
						state <= FETCH;
					end
				end
				FETCH: begin
					if (cnt < 9'd63) begin
						sram_address <= IN_BASE + sram_addr_t'(cnt + 9'd1);
					end
					if (cnt == 9'(63 + SRAM_READ_LATENCY)) begin
						cnt <= '0;
						state <= ROW;
					end else begin
						cnt <= cnt + 9'd1;
					end
				end
				ROW: begin
					mac_valid <= streaming;
					if (streaming) begin
						cnt <= cnt + 9'd1;
					end
					// column pass reads T over port B, so all of T lands first
					if (last_result) begin
						cnt <= '0;
						state <= COL;
					end
				end
				COL: begin
					mac_valid <= 1'b1;
					cnt <= cnt + 9'd1;
					if (cnt == 9'd255) begin
						state <= FLUSH;
					end
				end
				FLUSH: begin
					if (last_result) begin
						cnt <= '0;
						state <= STORE;
					end
				end
				STORE: begin
					// pair m is read at cnt m and written at cnt m+1
					if (cnt != 9'd0) begin
						sram_address <= OUT_BASE + sram_addr_t'(cnt - 9'd1);
						sram_we_n <= 1'b0;
					end
					if (cnt == 9'd32) begin
						state <= DONE;
					end
					cnt <= cnt + 9'd1;
				end
				DONE: begin
					sram_we_n <= 1'b1;
					done <= 1'b1;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// lane step lines up with the buffer read data one cycle later
	always_ff @(posedge clock) begin
		mac_ctrl.pass <= (state == COL) ? COL_PASS : ROW_PASS;
		mac_ctrl.step <= step;
		mac_ctrl.out_index <= (state == COL) ? idx_hi : idx_mid;
		mac_ctrl.first <= (step == 2'd0);
		mac_ctrl.last <= (step == 2'(PAIRS - 1));
		if (state == FETCH && !fetch_idx[0]) begin
			s_hold <= sram_read_data;
		end
		if (state == STORE) begin
			sram_write_data <= {q1_a[7:0], q1_b[7:0]};
		end
	end

endmodule

/* src/idct_top.sv */
`timescale 1ns/1ns

module idct_top
	import idct_math_pkg::*;
	import idct_mem_pkg::*;
(
	input logic clock,
	input logic resetn,
	input logic start,
	output logic done,
	output sram_addr_t sram_address,
	input sram_data_t sram_read_data,
	output sram_data_t sram_write_data,
	output logic sram_we_n
);

	ram_req_t req0_a;
	ram_req_t req0_b;
	ram_req_t req1_a;
	ram_req_t req1_b;
	buf_data_t q0_a;
	buf_data_t q0_b;
	buf_data_t q1_a;
	buf_data_t q1_b;
	mac_ctrl_t mac_ctrl;
	logic mac_valid;
	buf_data_t result_value;
	logic result_valid;

	idct_control u_control (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.done(done),
		.sram_address(sram_address),
		.sram_read_data(sram_read_data),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n),
		.req0_a(req0_a),
		.req0_b(req0_b),
		.req1_a(req1_a),
		.req1_b(req1_b),
		.q1_a(q1_a),
		.q1_b(q1_b),
		.mac_ctrl(mac_ctrl),
		.mac_valid(mac_valid),
		.result_value(result_value),
		.result_valid(result_valid)
	);

	// lane operands come straight from buffer 0
	idct_datapath u_datapath (
		.clock(clock),
		.resetn(resetn),
		.ctrl(mac_ctrl),
		.valid(mac_valid),
		.q_a(q0_a),
		.q_b(q0_b),
		.result_value(result_value),
		.result_valid(result_valid)
	);

	dual_port_ram u_buf0 (
		.clock(clock),
		.req_a(req0_a),
		.req_b(req0_b),
		.q_a(q0_a),
		.q_b(q0_b)
	);

	dual_port_ram u_buf1 (
		.clock(clock),
		.req_a(req1_a),
		.req_b(req1_b),
		.q_a(q1_a),
		.q_b(q1_b)
	);

endmodule

/* test/idct_assertions.sv */
`timescale 1ns/1ns

module idct_assertions
	import idct_mem_pkg::*;
(
	input logic clock,
	input logic resetn,
	input logic start,
	input logic done,
	input sram_addr_t sram_address,
	input logic sram_we_n
);

	int unsigned fail_count = 0;
	logic started;
	logic busy;
	logic accept;
	logic fetch_phase;
	logic [31:0] written;
	logic [63:0] read_seen;
	int unsigned lat_cnt;
	int unsigned ref_lat;
	sram_addr_t out_off;
	sram_addr_t in_off;

	// a start is taken while idle or in the cycle that shows done
	assign accept = start && (!busy || done);
	assign out_off = sram_address - OUT_BASE;
	assign in_off = sram_address - IN_BASE;

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			started <= 1'b0;
			busy <= 1'b0;
			fetch_phase <= 1'b0;
			written <= '0;
			read_seen <= '0;
			lat_cnt <= 0;
			ref_lat <= 0;
		end else begin
			started <= started || start;
			busy <= accept || (busy && !done);
			lat_cnt <= accept ? 0 : lat_cnt + 1;
			// first block sets the reference latency
			if (done && ref_lat == 0) begin
				ref_lat <= lat_cnt;
			end
			if (accept) begin
				fetch_phase <= 1'b1;
				read_seen <= '0;
			end else if (!sram_we_n) begin
				fetch_phase <= 1'b0;
			end else if (fetch_phase && in_off < 18'd64) begin
				read_seen[in_off[5:0]] <= 1'b1;
			end
			if (done) begin
				written <= '0;
			end else if (!sram_we_n && out_off < 18'd32) begin
				written[out_off[4:0]] <= 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!resetn)
		!started |-> !done && sram_we_n)
	else begin
		fail_count++;
		$error("done or an SRAM write seen before the first start");
	end

	assert property (@(posedge clock) disable iff (!resetn)
		!sram_we_n |-> out_off < 18'd32 && !written[out_off[4:0]])
	else begin
		fail_count++;
		$error("SRAM write outside the pixel region or to a word already written");
	end

	// done only for an accepted start, after a full block and the usual latency
	assert property (@(posedge clock) disable iff (!resetn)
		done |-> busy && (&written) && (ref_lat == 0 || lat_cnt == ref_lat))
	else begin
		fail_count++;
		$error("done without a start, before all pixels, or after a different latency");
	end

	assert property (@(posedge clock) disable iff (!resetn)
		done |=> !done)
	else begin
		fail_count++;
		$error("done held for more than one cycle");
	end

	assert property (@(posedge clock) disable iff (!resetn)
		fetch_phase |-> (sram_we_n && in_off < 18'd64) || (!sram_we_n && (&read_seen)))
	else begin
		fail_count++;
		$error("read outside the coefficient region or write before the fetch ended");
	end

endmodule

/* test/idct_tb.sv */
`timescale 1ns/1ns

module idct_tb
	import idct_mem_pkg::*;
();

	localparam int CLOCK_PERIOD = 20;
	localparam int NUM_BLOCKS = 5;
	// fetch, row pass, column pass and store of one block
	localparam int BLOCK_CYCLES = 64 + 256 + 256 + 32;
	localparam int WATCHDOG_NS = (2 * NUM_BLOCKS * BLOCK_CYCLES + 100) * CLOCK_PERIOD;

	logic clock;
	logic resetn;
	logic start;
	logic done;
	sram_addr_t sram_address;
	sram_data_t sram_read_data;
	sram_data_t sram_write_data;
	logic sram_we_n;

	sram_data_t sram [2 ** $bits(sram_addr_t)];
	sram_data_t read_pipe [SRAM_READ_LATENCY + 1];
	int coefs [64];
	sram_data_t expected [32];

	idct_top u_dut (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.done(done),
		.sram_address(sram_address),
		.sram_read_data(sram_read_data),
		.sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n)
	);

	bind idct_top idct_assertions u_assertions (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.done(done),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// SRAM answers the address of SRAM_READ_LATENCY cycles ago
	always @(negedge clock) begin
		for (int i = SRAM_READ_LATENCY; i > 0; i--) begin
			read_pipe[i] = read_pipe[i - 1];
		end
		read_pipe[0] = sram[sram_address];
		sram_read_data <= read_pipe[SRAM_READ_LATENCY];
		if (!sram_we_n) begin
			sram[sram_address] = sram_write_data;
		end
	end

	task automatic stop_with_failure();
		$display("Verification failed");
		$fatal(1);
	endtask

	// basis entry scaled by 4096, truncated toward zero
	function automatic int cosine(input int k, input int n);
		real scale;
		scale = (k == 0) ? 2048.0 / $sqrt(2.0) : 2048.0;
		return $rtoi(scale * $cos((2 * n + 1) * k * 3.14159265358979 / 16.0));
	endfunction

	task automatic fill_random();
		for (int i = 0; i < 64; i++) begin
			coefs[i] = int'($urandom_range(511)) - 256;
		end
	endtask

	task automatic fill_dc(input int dc);
		for (int i = 0; i < 64; i++) begin
			coefs[i] = 0;
		end
		coefs[0] = dc;
	endtask

	task automatic compute_expected();
		int t [64];
		logic [7:0] pix [64];
		int s;
		for (int r = 0; r < 8; r++) begin
			for (int n = 0; n < 8; n++) begin
				s = 0;
				for (int k = 0; k < 8; k++) begin
					s += coefs[r * 8 + k] * cosine(k, n);
				end
				t[r * 8 + n] = s >>> 8;
			end
		end
		// column pass, pixel byte sits at bit 16 and saturates
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				s = 0;
				for (int k = 0; k < 8; k++) begin
					s += cosine(k, r) * t[k * 8 + c];
				end
				if (s < 0) begin
					pix[r * 8 + c] = 8'd0;
				end else if (s >= (1 << 24)) begin
					pix[r * 8 + c] = 8'd255;
				end else begin
					pix[r * 8 + c] = s[23:16];
				end
			end
		end
		for (int m = 0; m < 32; m++) begin
			expected[m] = {pix[2 * m], pix[2 * m + 1]};
		end
	endtask

	task automatic check_output();
		for (int m = 0; m < 32; m++) begin
			assert (sram[OUT_BASE + sram_addr_t'(m)] === expected[m]) else begin
				$display("[ERROR] %0t: output word %0d is %h, expected %h",
					$time, m, sram[OUT_BASE + sram_addr_t'(m)], expected[m]);
				stop_with_failure();
			end
		end
	endtask

	// called on a falling edge, returns on the falling edge that shows done
	task automatic run_block(input bit restart_midway);
		compute_expected();
		for (int i = 0; i < 64; i++) begin
			sram[IN_BASE + sram_addr_t'(i)] = sram_data_t'(coefs[i]);
		end
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (restart_midway) begin
			repeat (100) @(negedge clock);
			start = 1'b1;
			@(negedge clock);
			start = 1'b0;
		end
		while (!done) begin
			@(negedge clock);
		end
		check_output();
	endtask

	always @(negedge clock) begin
		if (u_dut.u_assertions.fail_count != 0) begin
			$display("a bound protocol assertion failed");
			stop_with_failure();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the engine did not finish all blocks in time");
		stop_with_failure();
	end

	initial begin
		clock = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		sram_read_data = '0;
		void'($urandom(82884));
		repeat (4) @(negedge clock);
		resetn = 1'b1;
		repeat (5) @(negedge clock);
		fill_random();
		run_block(1'b1);
		// each further block starts in the cycle that shows done
		fill_random();
		run_block(1'b0);
		fill_dc(8000);
		run_block(1'b0);
		fill_dc(-8000);
		run_block(1'b0);
		fill_random();
		run_block(1'b0);
		repeat (4) @(negedge clock);
		if (u_dut.u_assertions.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("protocol assertions failed near the end of the run");
			stop_with_failure();
		end
	end

endmodule

/* idct_top.f */
src/idct_math_pkg.sv
src/idct_mem_pkg.sv
src/dual_port_ram.sv
src/mac_lane.sv
src/idct_datapath.sv
src/idct_control.sv
src/idct_top.sv
test/idct_assertions.sv
test/idct_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module idct_tb -f idct_top.f -o idct_sim \
	&& ./obj_dir/idct_sim +verilator+error+limit+100 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -qx "Verification passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
